//--- files.f
hw/pcs_block_pkg.sv
hw/pcs_sync_pkg.sv
hw/block_sync_if.sv
hw/block_aligner.sv
hw/block_sync_fsm.sv
hw/descrambler.sv
hw/pcs_rx_top.sv
verif/pcs_rx_assertions.sv
verif/pcs_rx_checker.sv
verif/pcs_rx_tb.sv

//--- hw/block_aligner.sv
// block aligner: joins current and previous word, tests the header, shifts out the block
`timescale 1ns/100ps
`default_nettype none

module block_aligner
(
    input  logic                                  i_clock,
    input  logic                                  i_rst_n,
    input  logic                                  i_valid,     // new word this cycle
    input  logic                                  i_signal_ok,
    input  logic [pcs_block_pkg::NB_CODED_BLOCK-1:0] i_data,
    block_sync_if.aligner                         sync,
    output logic [pcs_block_pkg::NB_CODED_BLOCK-1:0] o_block,
    output logic                                  o_block_valid
);
    import pcs_block_pkg::*;

    localparam int NB_EXT = 2 * NB_CODED_BLOCK; // 132 bit extension

    logic [NB_CODED_BLOCK-1:0] data_prev;    // last valid word
    logic [NB_EXT-1:0]         data_ext;
    logic [NB_CODED_BLOCK-1:0] data_shifted; // block at the locked offset

    // bits arrive lsb first, so the older word sits in the low half
    // offset k takes cur[65-k:0] on top of prev[65:66-k]
    assign data_ext = {i_data, data_prev};

    // header is the top two bits of the window at the search offset
    assign sync.sh_valid = ^data_ext[(NB_EXT - 1 - int'(sync.search_index)) -: NB_SH];

    assign data_shifted = data_ext[(NB_EXT - 1 - int'(sync.block_index)) -: NB_CODED_BLOCK];

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n || !i_signal_ok)
        begin
            data_prev <= '0; // signal loss drops the partial block too
        end
        else if (i_valid)
        begin
            data_prev <= i_data;
        end
    end

    // strobe only while locked, one cycle after the word
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            o_block_valid <= 1'b0;
        end
        else
        begin
            o_block_valid <= i_valid & sync.block_lock;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_block <= data_shifted; // held until the next word
        end
    end

endmodule

`default_nettype wire

//--- hw/block_sync_fsm.sv
// block lock FSM: slips the search offset until headers hold, then watches for header errors
`timescale 1ns/100ps
`default_nettype none

module block_sync_fsm
#(
    parameter int P_MAX_WINDOW     = pcs_sync_pkg::MAX_WINDOW,
    parameter int P_MAX_INVALID_SH = pcs_sync_pkg::MAX_INVALID_SH
)
(
    input  logic                                  i_clock,
    input  logic                                  i_rst_n,
    input  logic                                  i_valid,
    input  logic                                  i_signal_ok,
    input  logic [pcs_sync_pkg::NB_WINDOW_CNT-1:0]  i_unlocked_timer_limit, // good headers to lock
    input  logic [pcs_sync_pkg::NB_WINDOW_CNT-1:0]  i_locked_timer_limit,   // locked window length
    input  logic [pcs_sync_pkg::NB_INVALID_CNT-1:0] i_sh_invalid_limit,     // bad headers to unlock
    block_sync_if.fsm                             sync
);
    import pcs_block_pkg::*;

    localparam int NB_WIN = $clog2(P_MAX_WINDOW);
    localparam int NB_INV = $clog2(P_MAX_INVALID_SH);

    localparam logic [NB_INDEX-1:0] MAX_INDEX = NB_INDEX'(NB_CODED_BLOCK - 1); // 65

    localparam logic ST_UNLOCKED = 1'b0;
    localparam logic ST_LOCKED   = 1'b1;

    logic                state;        // doubles as the lock flag
    logic [NB_WIN-1:0]   win_cnt;      // good headers while unlocked, valid words while locked
    logic [NB_INV-1:0]   inv_cnt;      // bad headers in the current locked window
    logic [NB_WIN-1:0]   win_next;
    logic [NB_INV-1:0]   inv_next;
    logic [NB_INDEX-1:0] search_index;
    logic [NB_INDEX-1:0] block_index;
    logic                unlock_done;  // enough good headers in a row
    logic                window_done;  // end of the locked window
    logic                too_many_bad;

    assign win_next = win_cnt + 1'b1;
    // saturate, a window can be longer than the bad count can hold
    assign inv_next = (!sync.sh_valid && (inv_cnt != '1)) ? inv_cnt + 1'b1 : inv_cnt;

    assign unlock_done  = win_next >= NB_WIN'(i_unlocked_timer_limit);
    assign window_done  = win_next >= NB_WIN'(i_locked_timer_limit);
    assign too_many_bad = inv_next >= NB_INV'(i_sh_invalid_limit); // counts this word's header too

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n || !i_signal_ok)
        begin
            state        <= ST_UNLOCKED; // signal loss acts like a reset
            win_cnt      <= '0;
            inv_cnt      <= '0;
            search_index <= '0;
            block_index  <= '0;
        end
        else if (i_valid)
        begin
            case (state)
                ST_UNLOCKED :
                begin
                    if (sync.sh_valid)
                    begin
                        if (unlock_done)
                        begin
                            state       <= ST_LOCKED;
                            block_index <= search_index; // freeze the winning offset
                            win_cnt     <= '0;
                            inv_cnt     <= '0;
                        end
                        else
                        begin
                            win_cnt <= win_next;
                        end
                    end
                    else
                    begin
                        win_cnt      <= '0; // slip one bit and start over
                        search_index <= (search_index == MAX_INDEX) ? '0 : search_index + 1'b1;
                    end
                end
                default :
                begin
                    search_index <= block_index;
                    if (window_done)
                    begin
                        win_cnt <= '0;
                        inv_cnt <= '0;
                        if (too_many_bad)
                        begin
                            state <= ST_UNLOCKED; // search resumes at the same offset
                        end
                    end
                    else
                    begin
                        win_cnt <= win_next;
                        inv_cnt <= inv_next;
                    end
                end
            endcase
        end
    end

    assign sync.search_index = search_index;
    assign sync.block_index  = block_index;
    assign sync.block_lock   = state;

endmodule

`default_nettype wire

//--- hw/block_sync_if.sv
// aligner to lock FSM link: header check result one way, offsets and lock the other
`timescale 1ns/100ps
`default_nettype none

interface block_sync_if
(
    input logic valid,     // copy of the word strobe
    input logic signal_ok  // copy of the PMA signal detect
);
    import pcs_block_pkg::*;

    logic                sh_valid;     // header at search_index is 01 or 10, combinational
    logic [NB_INDEX-1:0] search_index; // offset under test
    logic [NB_INDEX-1:0] block_index;  // offset used for the block shift
    logic                block_lock;

    // aligner computes the header check and shifts with the offsets
    modport aligner (input valid, input signal_ok, output sh_valid,
                     input search_index, input block_index, input block_lock);

    // FSM owns the offsets and the lock flag
    modport fsm (input valid, input signal_ok, input sh_valid,
                 output search_index, output block_index, output block_lock);

endinterface

`default_nettype wire

//--- hw/descrambler.sv
// self-synchronizing descrambler 1 + x^39 + x^58 over the payload, header passes through
`timescale 1ns/100ps
`default_nettype none

module descrambler
(
    input  logic                                  i_clock,
    input  logic                                  i_rst_n,
    input  logic                                  i_valid,
    input  logic [pcs_block_pkg::NB_CODED_BLOCK-1:0] i_block,
    output logic [pcs_block_pkg::NB_CODED_BLOCK-1:0] o_block,
    output logic                                  o_valid,
    output logic                                  o_is_control
);
    import pcs_block_pkg::*;

    localparam int NB_SCR_STATE = 58; // highest tap
    localparam int TAP_A        = 39;
    localparam int NB_SEQ       = NB_SCR_STATE + NB_PAYLOAD;

    coded_block_u           blk_in;
    coded_block_u           blk_out;
    logic [NB_SCR_STATE-1:0] scr_hist;     // last 58 scrambled bits, bit 0 oldest
    logic [NB_SEQ-1:0]       scr_seq;      // history then payload, in arrival order
    logic [NB_PAYLOAD-1:0]   payload_clear;

    assign blk_in  = i_block;
    assign scr_seq = {blk_in.data.payload, scr_hist};

    // payload bit i sits at seq[i+58], taps 39 and 58 bits back
    always_comb
    begin
        for (int i = 0; i < NB_PAYLOAD; i++)
        begin
            payload_clear[i] = scr_seq[i + NB_SCR_STATE]
                             ^ scr_seq[i + NB_SCR_STATE - TAP_A]
                             ^ scr_seq[i];
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            blk_out.data.sh      <= blk_in.data.sh;
            blk_out.data.payload <= payload_clear;
            scr_hist             <= scr_seq[NB_SEQ-1 -: NB_SCR_STATE]; // keeps received bits
            o_is_control         <= (blk_in.data.sh == SH_CTRL);
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    assign o_block = blk_out;

endmodule

`default_nettype wire

//--- hw/pcs_block_pkg.sv
// 64b/66b block format: widths, sync header codes and the two views of a coded block
`default_nettype none

package pcs_block_pkg;

    parameter int NB_CODED_BLOCK = 66;                     // sync header + payload
    parameter int NB_PAYLOAD     = 64;
    parameter int NB_SH          = 2;
    parameter int NB_INDEX       = $clog2(NB_CODED_BLOCK); // 7 bits, offsets 0..65
    parameter int NB_BLOCK_TYPE  = 8;                      // first payload byte of a ctrl block
    parameter int NB_CTRL_BODY   = NB_PAYLOAD - NB_BLOCK_TYPE;

    // only these two headers are legal, 00 and 11 are header errors
    parameter logic [NB_SH-1:0] SH_DATA = 2'b01;
    parameter logic [NB_SH-1:0] SH_CTRL = 2'b10;

    typedef struct packed {
        logic [NB_SH-1:0]      sh;
        logic [NB_PAYLOAD-1:0] payload;
    } data_block_s;

    typedef struct packed {
        logic [NB_SH-1:0]         sh;
        logic [NB_BLOCK_TYPE-1:0] block_type;
        logic [NB_CTRL_BODY-1:0]  body;
    } ctrl_block_s;

    // same 66 bits, read as data or as control depending on sh
    typedef union packed {
        data_block_s data;
        ctrl_block_s ctrl;
    } coded_block_u;

endpackage

`default_nettype wire

//--- hw/pcs_rx_top.sv
// 64b/66b receive path: block aligner, lock FSM and descrambler
`timescale 1ns/100ps
`default_nettype none

module pcs_rx_top
#(
    parameter int P_MAX_WINDOW     = pcs_sync_pkg::MAX_WINDOW,
    parameter int P_MAX_INVALID_SH = pcs_sync_pkg::MAX_INVALID_SH
)
(
    input  logic                                  i_clock,
    input  logic                                  i_rst_n,
    input  logic                                  i_valid,   // word strobe from the SERDES side
    input  logic                                  i_signal_ok,
    input  logic [pcs_block_pkg::NB_CODED_BLOCK-1:0] i_data,
    input  logic [pcs_sync_pkg::NB_WINDOW_CNT-1:0]  i_unlocked_timer_limit,
    input  logic [pcs_sync_pkg::NB_WINDOW_CNT-1:0]  i_locked_timer_limit,
    input  logic [pcs_sync_pkg::NB_INVALID_CNT-1:0] i_sh_invalid_limit,
    output logic [pcs_block_pkg::NB_CODED_BLOCK-1:0] o_data,  // descrambled block
    output logic                                  o_valid,   // two cycles after i_valid
    output logic                                  o_is_control,
    output logic                                  o_block_lock
);
    import pcs_block_pkg::*;

    logic [NB_CODED_BLOCK-1:0] aligned_block;
    logic                      aligned_valid;

    block_sync_if sync (.valid(i_valid), .signal_ok(i_signal_ok));

    block_aligner u_block_aligner
    (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_signal_ok  (i_signal_ok),
        .i_data       (i_data),
        .sync         (sync.aligner),
        .o_block      (aligned_block),
        .o_block_valid(aligned_valid)
    );

    block_sync_fsm
    #(
        .P_MAX_WINDOW    (P_MAX_WINDOW),
        .P_MAX_INVALID_SH(P_MAX_INVALID_SH)
    )
    u_block_sync_fsm
    (
        .i_clock               (i_clock),
        .i_rst_n               (i_rst_n),
        .i_valid               (i_valid),
        .i_signal_ok           (i_signal_ok),
        .i_unlocked_timer_limit(i_unlocked_timer_limit),
        .i_locked_timer_limit  (i_locked_timer_limit),
        .i_sh_invalid_limit    (i_sh_invalid_limit),
        .sync                  (sync.fsm)
    );

    descrambler u_descrambler
    (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_valid     (aligned_valid), // only locked blocks get here
        .i_block     (aligned_block),
        .o_block     (o_data),
        .o_valid     (o_valid),
        .o_is_control(o_is_control)
    );

    assign o_block_lock = sync.block_lock;

endmodule

`default_nettype wire

//--- hw/pcs_sync_pkg.sv
// block lock control sizing: window and invalid header bounds and counter widths
`default_nettype none

package pcs_sync_pkg;

    // upper bound of the unlocked and locked timer windows
    parameter int MAX_WINDOW     = 4096;

    // upper bound of the invalid header limit while locked
    parameter int MAX_INVALID_SH = MAX_WINDOW / 2;

    // widths of the limit inputs and the counters behind them
    parameter int NB_WINDOW_CNT  = $clog2(MAX_WINDOW);     // 12 bits
    parameter int NB_INVALID_CNT = $clog2(MAX_INVALID_SH); // 11 bits

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the receive path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module pcs_rx_tb -o pcs_rx_sim

out=$(./obj_dir/pcs_rx_sim +verilator+error+limit+1000 2>&1) || true
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

//--- verif/pcs_rx_assertions.sv
// lock FSM assertions: offset range, lock rise on a valid word, lock clear on signal loss
`timescale 1ns/100ps
`default_nettype none

module pcs_rx_assertions
(
    input logic                               i_clock,
    input logic                               i_rst_n,
    input logic                               i_valid,
    input logic                               i_signal_ok,
    input logic [pcs_block_pkg::NB_INDEX-1:0] i_search_index,
    input logic                               i_block_lock
);
    int fail_count = 0; // read by the testbench at the end of the run

    // search offset stays inside one 66 bit block
    index_range : assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_search_index <= 7'd65)
        else begin fail_count++; $error("search_index out of range"); end

    // lock can only come from a header test on a valid word
    lock_on_valid : assert property (@(posedge i_clock) disable iff (!i_rst_n)
        $rose(i_block_lock) |-> $past(i_valid))
        else begin fail_count++; $error("lock rose without a valid word"); end

    // signal loss drops lock at the next edge
    lock_clear : assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !i_signal_ok |=> !i_block_lock)
        else begin fail_count++; $error("lock held after signal loss"); end

endmodule

bind block_sync_fsm pcs_rx_assertions u_fsm_assertions
(
    .i_clock       (i_clock),
    .i_rst_n       (i_rst_n),
    .i_valid       (i_valid),
    .i_signal_ok   (i_signal_ok),
    .i_search_index(search_index),
    .i_block_lock  (state)
);

`default_nettype wire

//--- verif/pcs_rx_checker.sv
// receive path checker: follows words through lock, compares descrambled blocks and lock state
`timescale 1ns/100ps
`default_nettype none

module pcs_rx_checker
(
    input logic                                      i_clock,
    input logic                                      i_valid,      // DUT word strobe
    input logic                                      i_block_lock,
    input logic                                      i_out_valid,
    input logic                                      i_is_control,
    input logic [pcs_block_pkg::NB_CODED_BLOCK-1:0] i_data
);
    import pcs_block_pkg::*;

    coded_block_u exp_q[$];  // one clear block per driven word
    coded_block_u pend_q[$]; // words that went in while locked
    int           pend_t[$]; // edge at which each locked word went in
    bit           skip_q[$]; // first block after a lock rise sees a stale history
    coded_block_u exp_blk;
    coded_block_u got;
    logic         lock_q = 1'b0;
    int           edge_no = 0;
    int           lat;
    int           words = 0;
    int           rises = 0;
    int           falls = 0;
    int           first_lock_word = -1;
    int           lock_lim = 0;     // locked window length in words
    int           inv_lim = 0;      // bad headers per window that end lock
    int           win_words = 0;    // locked words in the current window
    int           win_bad = 0;      // bad headers in the current window
    bit           drop_due = 1'b0;  // last window ended over the bad header limit
    int           data_errors = 0;
    int           lock_errors = 0;
    int           other_errors = 0;

    function automatic int error_count();
        return data_errors + lock_errors + other_errors;
    endfunction

    task automatic push_expected(input coded_block_u blk);
        exp_q.push_back(blk);
    endtask

    task automatic start_row(input int locked_limit, input int invalid_limit);
        words           = 0;
        rises           = 0;
        falls           = 0;
        first_lock_word = -1;
        lock_lim        = locked_limit;
        inv_lim         = invalid_limit;
        win_words       = 0;
        win_bad         = 0;
        drop_due        = 1'b0;
        exp_q.delete();
    endtask

    always @(posedge i_clock)
    begin
        edge_no++;
        if (drop_due)
        begin
            drop_due = 1'b0;
            if (i_block_lock)
            begin
                lock_errors++;
                $display("mismatch at %0t: lock held after a window over the bad header limit",
                         $time);
            end
        end
        if (i_block_lock && !lock_q)
        begin
            rises++;
            win_words = 0;
            win_bad   = 0;
            if (first_lock_word < 0)
                first_lock_word = words; // words seen before the first lock
        end
        if (!i_block_lock && lock_q)
        begin
            falls++;
            win_words = 0;
            win_bad   = 0;
        end
        if (i_valid)
        begin
            words++;
            if (exp_q.size() == 0)
            begin
                other_errors++;
                $display("%0t: word strobe with no expected block queued", $time);
            end
            else
            begin
                exp_blk = exp_q.pop_front();
                if (i_block_lock)
                begin
                    pend_q.push_back(exp_blk);
                    pend_t.push_back(edge_no);
                    skip_q.push_back(!lock_q); // lock just rose
                    // locked window model, 00 and 11 count as bad
                    win_words++;
                    if (exp_blk.data.sh[1] == exp_blk.data.sh[0])
                        win_bad++;
                    if (win_words == lock_lim)
                    begin
                        drop_due  = (win_bad >= inv_lim);
                        win_words = 0;
                        win_bad   = 0;
                    end
                end
            end
        end
        if (i_out_valid)
        begin
            got = i_data;
            if (pend_q.size() == 0)
            begin
                other_errors++;
                $display("%0t: output block with no locked word behind it", $time);
            end
            else
            begin
                exp_blk = pend_q.pop_front();
                lat     = edge_no - pend_t.pop_front();
                if (lat != 2)
                begin
                    data_errors++;
                    $display("mismatch at %0t: output latency expected 2 got %0d", $time, lat);
                end
                if (!skip_q.pop_front())
                begin
                    if (got !== exp_blk)
                    begin
                        data_errors++;
                        $display("mismatch at %0t: block expected %h got %h", $time, exp_blk, got);
                    end
                    if (i_is_control !== (exp_blk.data.sh == SH_CTRL))
                    begin
                        data_errors++;
                        $display("mismatch at %0t: control flag expected %0b got %0b", $time,
                                 exp_blk.data.sh == SH_CTRL, i_is_control);
                    end
                    // block type through the control view
                    if (exp_blk.data.sh == SH_CTRL && got.ctrl.block_type !== exp_blk.ctrl.block_type)
                    begin
                        data_errors++;
                        $display("mismatch at %0t: block type expected %h got %h", $time,
                                 exp_blk.ctrl.block_type, got.ctrl.block_type);
                    end
                end
            end
        end
        lock_q = i_block_lock;
    end

    // end of row checks of final lock, time to lock, lock drops and pending blocks
    task automatic check_row(input int row, input bit exp_lock, input bit exp_drop, input int bound);
        if (i_block_lock !== exp_lock)
        begin
            lock_errors++;
            $display("mismatch at %0t: row %0d lock expected %0b got %0b", $time, row, exp_lock,
                     i_block_lock);
        end
        if (exp_lock && (first_lock_word < 0 || first_lock_word > bound))
        begin
            lock_errors++;
            $display("row %0d: first lock after %0d words, allowed %0d", row, first_lock_word, bound);
        end
        if (!exp_lock && rises != 0)
        begin
            lock_errors++;
            $display("row %0d: lock rose %0d times on a stream of bad headers", row, rises);
        end
        if ((falls != 0) != exp_drop)
        begin
            lock_errors++;
            $display("mismatch at %0t: row %0d lock drops expected %0b got %0d", $time, row,
                     exp_drop, falls);
        end
        if (pend_q.size() != 0)
        begin
            other_errors++;
            $display("row %0d: %0d locked words never came out of the DUT", row, pend_q.size());
        end
        pend_q.delete();
        pend_t.delete();
        skip_q.delete();
    endtask

endmodule

`default_nettype wire

//--- verif/pcs_rx_tb.sv
// receive path testbench: table driven scrambled block streams at chosen bit offsets
`timescale 1ns/100ps
`default_nettype none

module pcs_rx_tb;
    import pcs_block_pkg::*;
    import pcs_sync_pkg::*;

    localparam int          PERIOD      = 8;
    localparam int          DRIVE_DELAY = 1;
    localparam int          NUM_ROWS    = 8;
    localparam int          MAX_BLOCKS  = 800;
    localparam logic [31:0] SEED        = 32'd90;

    typedef struct {
        int offset;     // lock offset the stream is rotated to
        int n_blocks;
        int unlock_lim;
        int lock_lim;
        int inv_lim;
        int bad_cnt;    // headers forced to 00 or 11
        int bad_pos;    // also the word where signal_ok drops
        bit drop_sig;
        bit exp_lock;   // lock at the end of the row
        bit exp_drop;   // lock must fall during the row
    } row_t;

    row_t                          rows [NUM_ROWS];
    logic [7:0]                    ctrl_types [15];
    logic                          i_clock;
    logic                          i_rst_n;
    logic                          i_valid;
    logic                          i_signal_ok;
    logic [NB_CODED_BLOCK-1:0]     i_data;
    logic [NB_WINDOW_CNT-1:0]      i_unlocked_timer_limit;
    logic [NB_WINDOW_CNT-1:0]      i_locked_timer_limit;
    logic [NB_INVALID_CNT-1:0]     i_sh_invalid_limit;
    logic [NB_CODED_BLOCK-1:0]     o_data;
    logic                          o_valid;
    logic                          o_is_control;
    logic                          o_block_lock;
    coded_block_u                  clr_blk [MAX_BLOCKS+1];
    logic [NB_CODED_BLOCK-1:0]     tx_blk [MAX_BLOCKS+1];
    logic [57:0]                   scr_sr;     // bit 0 newest scrambled bit
    logic [31:0]                   lcg;
    int                            cycles = 0;
    int                            timeout_limit = 1000000;

    pcs_rx_top dut (.*);

    pcs_rx_checker chk
    (
        .i_clock     (i_clock),
        .i_valid     (i_valid),
        .i_block_lock(o_block_lock),
        .i_out_valid (o_valid),
        .i_is_control(o_is_control),
        .i_data      (o_data)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #(PERIOD / 2) i_clock = ~i_clock;
    end

    always @(posedge i_clock)
    begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit)
        begin
            $display("timeout: run passed %0d cycles", timeout_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // serial scrambler 1 + x^39 + x^58 with payload bit 0 first
    task automatic scramble(input logic [63:0] clear, output logic [63:0] scr);
        logic b;
        for (int i = 0; i < 64; i++)
        begin
            b      = clear[i] ^ scr_sr[38] ^ scr_sr[57];
            scr[i] = b;
            scr_sr = {scr_sr[56:0], b};
        end
    endtask

    task automatic wait_cycle();
        @(posedge i_clock);
        #DRIVE_DELAY;
    endtask

    task automatic build_blocks(input row_t rw);
        coded_block_u blk;
        logic [31:0]  hi;
        logic [63:0]  scr;
        lcg    = SEED;
        scr_sr = '0;
        for (int b = 0; b <= rw.n_blocks; b++) // one extra block for the last word's tail
        begin
            lcg = lcg_next(lcg);
            hi  = lcg;
            lcg = lcg_next(lcg);
            blk.data.payload = {hi, lcg};
            lcg = lcg_next(lcg);
            if (lcg[20])
            begin
                blk.data.sh         = SH_CTRL;
                blk.ctrl.block_type = ctrl_types[(lcg >> 24) % 15];
            end
            else
                blk.data.sh = SH_DATA;
            if (b >= rw.bad_pos && b < rw.bad_pos + rw.bad_cnt)
                blk.data.sh = blk.data.sh ^ 2'b01; // 00 or 11
            scramble(blk.data.payload, scr);
            tx_blk[b]  = {blk.data.sh, scr};
            clr_blk[b] = blk;
        end
    endtask

    task automatic run_row(input int r);
        row_t         rw;
        logic [131:0] pair;
        rw                     = rows[r];
        i_valid                = 1'b0;
        i_signal_ok            = 1'b0; // clears lock left from the last row
        i_unlocked_timer_limit = NB_WINDOW_CNT'(rw.unlock_lim);
        i_locked_timer_limit   = NB_WINDOW_CNT'(rw.lock_lim);
        i_sh_invalid_limit     = NB_INVALID_CNT'(rw.inv_lim);
        repeat (2) wait_cycle();
        i_signal_ok = 1'b1;
        repeat (2) wait_cycle();
        chk.start_row(rw.lock_lim, rw.inv_lim);
        build_blocks(rw);
        for (int n = 0; n < rw.n_blocks; n++)
        begin
            pair        = {tx_blk[n+1], tx_blk[n]};
            i_data      = pair[rw.offset +: NB_CODED_BLOCK]; // block n starts at bit offset
            i_valid     = 1'b1;
            i_signal_ok = !(rw.drop_sig && n == rw.bad_pos);
            chk.push_expected(clr_blk[n]);
            wait_cycle();
        end
        i_valid     = 1'b0;
        i_signal_ok = 1'b1;
        repeat (4) wait_cycle(); // drain the two stage pipe
        chk.check_row(r, rw.exp_lock, rw.exp_drop, 4 * 66 + rw.unlock_lim);
    endtask

    initial
    begin
        int total;
        int errs;
        int asrt;
        //          off  blk  ul  ll  il  bad  pos drop lock fall
        rows[0] = '{0,   300, 32, 64, 4,  0,   0,   0,   1,   0};
        rows[1] = '{1,   300, 32, 64, 4,  0,   0,   0,   1,   0};
        rows[2] = '{37,  300, 32, 64, 4,  0,   0,   0,   1,   0};
        rows[3] = '{65,  300, 32, 64, 4,  0,   0,   0,   1,   0};
        rows[4] = '{37,  300, 32, 64, 4,  300, 0,   0,   0,   0}; // every header bad
        rows[5] = '{5,   700, 32, 64, 4,  8,   320, 0,   1,   1}; // unlock then relock
        rows[6] = '{20,  500, 32, 64, 4,  3,   320, 0,   1,   0}; // below the limit
        rows[7] = '{50,  600, 32, 64, 4,  0,   320, 1,   1,   1}; // signal_ok drop
        ctrl_types = '{8'h1e, 8'h2d, 8'h33, 8'h66, 8'h55, 8'h78, 8'h4b, 8'h87,
                       8'h99, 8'haa, 8'hb4, 8'hcc, 8'hd2, 8'he1, 8'hff};
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++)
            total += rows[r].n_blocks;
        timeout_limit = total * 4 + 200;
        i_rst_n                = 1'b0;
        i_valid                = 1'b0;
        i_signal_ok            = 1'b0;
        i_data                 = '0;
        i_unlocked_timer_limit = '0;
        i_locked_timer_limit   = '0;
        i_sh_invalid_limit     = '0;
        repeat (4) @(posedge i_clock);
        #DRIVE_DELAY;
        i_rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        errs = chk.error_count();
        asrt = dut.u_block_sync_fsm.u_fsm_assertions.fail_count;
        $display("errors: checker %0d, assertions %0d", errs, asrt);
        if (errs == 0 && asrt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
